//--- logic/readout_pkg.sv
// readout path shared definitions

package readout_pkg;

    // word in the output queue
    localparam int WORD_WIDTH = 32;

    // payload of one front-end hit channel
    localparam int HIT_WIDTH = 24;

    // set only in trigger words
    // bits below it carry the trigger number
    localparam int TRIGGER_FLAG_BIT = 31;

    // source identifier inside a hit word, bits 26 to 24
    // bits 30 to 27 and the flag bit stay zero
    localparam int TAG_LSB = 24;
    localparam int TAG_WIDTH = 3;

    // trigger acceptance FSM
    typedef enum logic [0:0]
    {
        TRIG_IDLE,
        TRIG_WAIT_READY
    } trig_state_t;

endpackage

//--- logic/trigger_unit.sv
// trigger acceptance and trigger words
`timescale 1ns/1ps

module trigger_unit
(
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_trigger,
    input  logic                               i_trigger_enable,
    input  logic                               i_veto,
    input  logic                               i_cmd_ready,
    input  logic                               i_queue_full,
    output logic                               o_cmd_start,
    output logic                               o_busy,
    output logic                               o_push,
    output logic [readout_pkg::WORD_WIDTH-1:0] o_word
);

    import readout_pkg::*;

    trig_state_t state;

    // registered copy of ready for edge detect
    logic ready_q;
    logic ready_rise;

    // running trigger number, fills the bits below the flag
    logic [TRIGGER_FLAG_BIT-1:0] trig_count;

    logic accept;

    // only idle, enabled, not vetoed and with room in the queue
    assign accept = i_trigger && (state == TRIG_IDLE) && i_trigger_enable
                    && !i_veto && !i_queue_full;

    // sequencer finished its command
    assign ready_rise = i_cmd_ready && !ready_q;

    // word goes into the trigger queue at the accept edge
    assign o_push = accept;

    always_comb
    begin
        o_word = '0;
        o_word[TRIGGER_FLAG_BIT] = 1'b1;
        o_word[TRIGGER_FLAG_BIT-1:0] = trig_count;
    end

    // busy for the whole wait on ready
    assign o_busy = (state == TRIG_WAIT_READY);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state       <= TRIG_IDLE;
            ready_q     <= 1'b0;
            trig_count  <= '0;
            o_cmd_start <= 1'b0;
        end
        else
        begin
            ready_q     <= i_cmd_ready;
            // one-cycle start pulse per accepted trigger
            o_cmd_start <= accept;
            case (state)
                TRIG_IDLE:
                begin
                    if (accept)
                    begin
                        // number used by this word, next one waits
                        trig_count <= trig_count + 1'b1;
                        state      <= TRIG_WAIT_READY;
                    end
                end
                TRIG_WAIT_READY:
                begin
                    // triggers in here are dropped without a number
                    if (ready_rise)
                    begin
                        state <= TRIG_IDLE;
                    end
                end
                default:
                begin
                    state <= TRIG_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/source_fifo.sv
// show-ahead source queue
`timescale 1ns/1ps

module source_fifo
#(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8,
    parameter int NEAR_FULL_LEVEL = 6
)
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full,
    output logic             o_near_full,
    output logic             o_overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_write;
    logic do_read;

    // push while full is lost, pop while empty is ignored
    assign do_write = i_push && !o_full;
    assign do_read  = i_pop && !o_empty;

    assign o_empty     = (count == '0);
    assign o_full      = (count == CNT_W'(DEPTH));
    assign o_near_full = (count >= CNT_W'(NEAR_FULL_LEVEL));

    // head word visible without a pop
    assign o_data = mem[rd_ptr];

    // storage array written on push
    always_ff @(posedge i_clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end
        else
        begin
            // circular pointers wrap after DEPTH-1
            if (do_write)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together keep the fill level
            if (do_write && !do_read)
            begin
                count <= count + 1'b1;
            end
            else if (do_read && !do_write)
            begin
                count <= count - 1'b1;
            end
            // sticky until reset
            if (i_push && o_full)
            begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

//--- logic/readout_arbiter.sv
// round-robin merge into output queue
`timescale 1ns/1ps

module readout_arbiter
#(
    parameter int N_HIT = 3
)
(
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    input  logic [N_HIT:0]                           i_src_enable,
    input  logic                                     i_trig_empty,
    input  logic [readout_pkg::WORD_WIDTH-1:0]       i_trig_word,
    input  logic [N_HIT-1:0]                         i_hit_empty,
    input  logic [N_HIT*readout_pkg::HIT_WIDTH-1:0]  i_hit_words,
    input  logic                                     i_out_full,
    output logic                                     o_trig_pop,
    output logic [N_HIT-1:0]                         o_hit_pop,
    output logic                                     o_out_push,
    output logic [readout_pkg::WORD_WIDTH-1:0]       o_out_word
);

    import readout_pkg::*;

    localparam int N_SRC = N_HIT + 1;
    localparam int IDX_W = $clog2(N_SRC);

    // source 0 is the trigger queue, source k is hit channel k-1
    logic [N_HIT:0]     req;
    logic [IDX_W-1:0]   last_grant;
    logic [IDX_W-1:0]   grant_idx;
    logic               grant_valid;

    assign req[0]       = i_src_enable[0] && !i_trig_empty;
    assign req[N_HIT:1] = i_src_enable[N_HIT:1] & ~i_hit_empty;

    // search starts one past the last granted source
    always_comb
    begin : grant_search
        int cand;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int off = 1; off <= N_SRC; off++)
        begin
            cand = (int'(last_grant) + off) % N_SRC;
            if (!grant_valid && req[cand])
            begin
                grant_valid = 1'b1;
                grant_idx   = IDX_W'(cand);
            end
        end
        // words wait in their queues while the output is full
        if (i_out_full)
        begin
            grant_valid = 1'b0;
        end
    end

    // pop and push land on the same edge
    assign o_out_push = grant_valid;
    assign o_trig_pop = grant_valid && (grant_idx == '0);

    always_comb
    begin
        o_hit_pop  = '0;
        o_out_word = i_trig_word;
        for (int k = 0; k < N_HIT; k++)
        begin
            if (grant_valid && (grant_idx == IDX_W'(k + 1)))
            begin
                o_hit_pop[k] = 1'b1;
                // payload low, channel+1 as tag, flag stays clear
                o_out_word = '0;
                o_out_word[HIT_WIDTH-1:0] = i_hit_words[k*HIT_WIDTH +: HIT_WIDTH];
                o_out_word[TAG_LSB +: TAG_WIDTH] = TAG_WIDTH'(k + 1);
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            // so the first search begins at the trigger source
            last_grant <= IDX_W'(N_SRC - 1);
        end
        else if (grant_valid)
        begin
            last_grant <= grant_idx;
        end
    end

endmodule

//--- logic/host_reader.sv
// host read port on output queue
`timescale 1ns/1ps

module host_reader
(
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_read,
    input  logic                               i_clear_error,
    input  logic                               i_empty,
    input  logic [readout_pkg::WORD_WIDTH-1:0] i_head,
    output logic                               o_pop,
    output logic [readout_pkg::WORD_WIDTH-1:0] o_data,
    output logic                               o_data_valid,
    output logic                               o_read_error
);

    // strobe only counts with data present
    assign o_pop = i_read && !i_empty;

    // head word captured on each pop
    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            o_data <= i_head;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_data_valid <= 1'b0;
            o_read_error <= 1'b0;
        end
        else
        begin
            o_data_valid <= o_pop;
            // sticky read-on-empty error
            // a new one wins over the clear
            o_read_error <= (o_read_error && !i_clear_error) || (i_read && i_empty);
        end
    end

endmodule

//--- logic/readout_top.sv
// trigger and hit readout top level
`timescale 1ns/1ps

module readout_top
#(
    parameter int N_HIT = 3,
    parameter int HIT_FIFO_DEPTH = 8,
    parameter int OUT_FIFO_DEPTH = 16,
    parameter int NEAR_FULL_LEVEL = 12
)
(
    input  logic                                    CLK_40,
    input  logic                                    i_rst,
    // trigger side
    input  logic                                    i_trigger,
    input  logic                                    i_trigger_enable,
    input  logic                                    i_veto,
    input  logic                                    i_cmd_ready,
    output logic                                    o_cmd_start,
    output logic                                    o_busy,
    // front-end hit channels
    input  logic [N_HIT-1:0]                        i_hit_valid,
    input  logic [N_HIT*readout_pkg::HIT_WIDTH-1:0] i_hit_data,
    // bit 0 trigger, bit k hit channel k-1
    input  logic [N_HIT:0]                          i_src_enable,
    // host side
    input  logic                                    i_read,
    input  logic                                    i_clear_error,
    output logic [readout_pkg::WORD_WIDTH-1:0]      o_data,
    output logic                                    o_data_valid,
    output logic                                    o_read_error,
    output logic                                    o_not_empty,
    output logic                                    o_full,
    output logic                                    o_near_full,
    output logic [N_HIT-1:0]                        o_hit_overflow
);

    import readout_pkg::*;

    // trigger queue
    logic                  trig_push;
    logic [WORD_WIDTH-1:0] trig_word_in;
    logic                  trig_full;
    logic                  trig_empty;
    logic                  trig_pop;
    logic [WORD_WIDTH-1:0] trig_head;

    // hit queues
    logic [N_HIT-1:0]           hit_empty;
    logic [N_HIT-1:0]           hit_pop;
    logic [N_HIT*HIT_WIDTH-1:0] hit_heads;

    // output queue
    logic                  out_push;
    logic [WORD_WIDTH-1:0] out_word;
    logic                  out_empty;
    logic                  out_pop;
    logic [WORD_WIDTH-1:0] out_head;

    assign o_not_empty = !out_empty;

    trigger_unit i_trigger_unit
    (
        .i_clk            (CLK_40),
        .i_rst            (i_rst),
        .i_trigger        (i_trigger),
        .i_trigger_enable (i_trigger_enable),
        .i_veto           (i_veto),
        .i_cmd_ready      (i_cmd_ready),
        .i_queue_full     (trig_full),
        .o_cmd_start      (o_cmd_start),
        .o_busy           (o_busy),
        .o_push           (trig_push),
        .o_word           (trig_word_in)
    );

    // full flag doubles as trigger veto, so no overflow here
    source_fifo #(.WIDTH(WORD_WIDTH), .DEPTH(HIT_FIFO_DEPTH),
                  .NEAR_FULL_LEVEL(HIT_FIFO_DEPTH)) i_trig_fifo
    (
        .i_clk(CLK_40), .i_rst(i_rst), .i_push(trig_push), .i_data(trig_word_in),
        .i_pop(trig_pop), .o_data(trig_head), .o_empty(trig_empty),
        .o_full(trig_full), .o_near_full(), .o_overflow()
    );

    // one queue per channel, pushed straight by the hit strobe
    for (genvar k = 0; k < N_HIT; k++)
    begin : g_hit_fifo
        source_fifo #(.WIDTH(HIT_WIDTH), .DEPTH(HIT_FIFO_DEPTH),
                      .NEAR_FULL_LEVEL(HIT_FIFO_DEPTH)) i_hit_fifo
        (
            .i_clk(CLK_40), .i_rst(i_rst), .i_push(i_hit_valid[k]),
            .i_data(i_hit_data[k*HIT_WIDTH +: HIT_WIDTH]), .i_pop(hit_pop[k]),
            .o_data(hit_heads[k*HIT_WIDTH +: HIT_WIDTH]), .o_empty(hit_empty[k]),
            .o_full(), .o_near_full(), .o_overflow(o_hit_overflow[k])
        );
    end

    readout_arbiter #(.N_HIT(N_HIT)) i_readout_arbiter
    (
        .i_clk        (CLK_40),
        .i_rst        (i_rst),
        .i_src_enable (i_src_enable),
        .i_trig_empty (trig_empty),
        .i_trig_word  (trig_head),
        .i_hit_empty  (hit_empty),
        .i_hit_words  (hit_heads),
        .i_out_full   (o_full),
        .o_trig_pop   (trig_pop),
        .o_hit_pop    (hit_pop),
        .o_out_push   (out_push),
        .o_out_word   (out_word)
    );

    // merge never pushes into a full queue
    source_fifo #(.WIDTH(WORD_WIDTH), .DEPTH(OUT_FIFO_DEPTH),
                  .NEAR_FULL_LEVEL(NEAR_FULL_LEVEL)) i_out_fifo
    (
        .i_clk(CLK_40), .i_rst(i_rst), .i_push(out_push), .i_data(out_word),
        .i_pop(out_pop), .o_data(out_head), .o_empty(out_empty),
        .o_full(o_full), .o_near_full(o_near_full), .o_overflow()
    );

    host_reader i_host_reader
    (
        .i_clk         (CLK_40),
        .i_rst         (i_rst),
        .i_read        (i_read),
        .i_clear_error (i_clear_error),
        .i_empty       (out_empty),
        .i_head        (out_head),
        .o_pop         (out_pop),
        .o_data        (o_data),
        .o_data_valid  (o_data_valid),
        .o_read_error  (o_read_error)
    );

endmodule

//--- testbench/readout_checker.sv
// readout top assertions
`timescale 1ns/1ps

module readout_checker
(
    input logic i_clk,
    input logic i_rst,
    input logic i_cmd_start,
    input logic i_busy,
    input logic i_full,
    input logic i_near_full,
    input logic i_read,
    input logic i_not_empty,
    input logic i_data_valid
);

    // failures seen so far
    int fail_count = 0;

    // start is a single-cycle pulse
    a_start_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_cmd_start |=> !i_cmd_start)
    else
    begin
        $error("o_cmd_start held for more than one cycle");
        fail_count++;
    end

    // busy comes up together with the start
    a_start_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        i_cmd_start |-> i_busy)
    else
    begin
        $error("o_cmd_start without o_busy");
        fail_count++;
    end

    a_busy_start: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_busy) |-> i_cmd_start)
    else
    begin
        $error("o_busy rose without a command start");
        fail_count++;
    end

    a_full_near: assert property (@(posedge i_clk) disable iff (i_rst)
        i_full |-> i_near_full)
    else
    begin
        $error("o_full without o_near_full");
        fail_count++;
    end

    // read on empty queue gives no data
    a_empty_read: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_read && !i_not_empty) |=> !i_data_valid)
    else
    begin
        $error("o_data_valid after a read on an empty queue");
        fail_count++;
    end

endmodule

bind readout_top readout_checker i_readout_checker
(
    .i_clk        (CLK_40),
    .i_rst        (i_rst),
    .i_cmd_start  (o_cmd_start),
    .i_busy       (o_busy),
    .i_full       (o_full),
    .i_near_full  (o_near_full),
    .i_read       (i_read),
    .i_not_empty  (o_not_empty),
    .i_data_valid (o_data_valid)
);

//--- testbench/tb_readout_top.sv
// readout path testbench
`timescale 1ns/1ps

module tb_readout_top;

    localparam int N_HIT = 3;
    localparam int HIT_W = 24;
    localparam int MAX_STEPS = 128;
    localparam int EXP_DEPTH = 64;

    logic                   CLK_40;
    logic                   i_rst;
    logic                   i_trigger;
    logic                   i_trigger_enable;
    logic                   i_veto;
    logic                   i_cmd_ready;
    logic                   o_cmd_start;
    logic                   o_busy;
    logic [N_HIT-1:0]       i_hit_valid;
    logic [N_HIT*HIT_W-1:0] i_hit_data;
    logic [N_HIT:0]         i_src_enable;
    logic                   i_read;
    logic                   i_clear_error;
    logic [31:0]            o_data;
    logic                   o_data_valid;
    logic                   o_read_error;
    logic                   o_not_empty;
    logic                   o_full;
    logic                   o_near_full;
    logic [N_HIT-1:0]       o_hit_overflow;

    // golden steps, one row per line of the file
    logic [31:0] step_test [MAX_STEPS];
    logic [31:0] step_act [MAX_STEPS];
    logic [31:0] step_arg [MAX_STEPS];
    logic [31:0] step_data [MAX_STEPS];
    logic [31:0] step_exp [MAX_STEPS];
    int n_steps;
    int step_cycles;
    int cycle_count;
    int cycle_limit;

    // expected words per source
    // 0 trigger, k hit channel k-1
    logic [31:0] exp_mem [N_HIT+1][EXP_DEPTH];
    int exp_wr [N_HIT+1];
    int exp_rd [N_HIT+1];

    int errors;
    int checks;
    int trig_num;
    logic model_busy;

    readout_top #(.N_HIT(N_HIT), .HIT_FIFO_DEPTH(8), .OUT_FIFO_DEPTH(16),
                  .NEAR_FULL_LEVEL(12)) i_readout_top
    (
        .CLK_40           (CLK_40),
        .i_rst            (i_rst),
        .i_trigger        (i_trigger),
        .i_trigger_enable (i_trigger_enable),
        .i_veto           (i_veto),
        .i_cmd_ready      (i_cmd_ready),
        .o_cmd_start      (o_cmd_start),
        .o_busy           (o_busy),
        .i_hit_valid      (i_hit_valid),
        .i_hit_data       (i_hit_data),
        .i_src_enable     (i_src_enable),
        .i_read           (i_read),
        .i_clear_error    (i_clear_error),
        .o_data           (o_data),
        .o_data_valid     (o_data_valid),
        .o_read_error     (o_read_error),
        .o_not_empty      (o_not_empty),
        .o_full           (o_full),
        .o_near_full      (o_near_full),
        .o_hit_overflow   (o_hit_overflow)
    );

    // 8 ns period
    always #4 CLK_40 = ~CLK_40;

    // run limit from the golden step lengths
    always @(posedge CLK_40)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("run stopped after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("at %0d ns: %s", $time, msg);
    endtask

    task automatic push_expected(input int src, input logic [31:0] word);
        if (exp_wr[src] < EXP_DEPTH)
        begin
            exp_mem[src][exp_wr[src]] = word;
            exp_wr[src]++;
        end
        else
        begin
            report_failure($sformatf("too many expected words for source %0d", src));
        end
    endtask

    // flag bit means trigger word, else tag picks the channel
    task automatic route_read_word(input logic [31:0] word);
        int src;
        src = word[31] ? 0 : int'(word[26:24]);
        if (!word[31] && (src == 0 || src > N_HIT || word[30:27] != 4'h0))
        begin
            report_failure($sformatf("read word %h carries no valid source tag", word));
        end
        else if (exp_rd[src] >= exp_wr[src])
        begin
            report_failure($sformatf("word %h from source %0d was not expected", word, src));
        end
        else
        begin
            check_value("o_data", word, exp_mem[src][exp_rd[src]]);
            exp_rd[src]++;
        end
    endtask

    // rough cycle cost of one step
    function automatic int step_length(input logic [31:0] act, input logic [31:0] arg,
                                       input logic [31:0] exp);
        case (act)
            32'h0: return int'(arg) + 1;
            32'h2: return 4;
            32'h3: return int'(exp[15:8]) + 2;
            32'h6: return 2 * int'(arg) + 2;
            default: return 2;
        endcase
    endfunction

    task automatic load_steps();
        int fd;
        int cnt;
        string line;
        logic [31:0] t, a, g, d, e;
        n_steps = 0;
        step_cycles = 8;
        fd = $fopen("testbench/readout_golden.txt", "r");
        if (fd == 0)
        begin
            report_failure("golden file testbench/readout_golden.txt could not be opened");
        end
        else
        begin
            while (!$feof(fd) && n_steps < MAX_STEPS)
            begin
                line = "";
                cnt = $fgets(line, fd);
                // comment lines give no fields
                cnt = $sscanf(line, "%h %h %h %h %h", t, a, g, d, e);
                if (cnt == 5)
                begin
                    step_test[n_steps] = t;
                    step_act[n_steps] = a;
                    step_arg[n_steps] = g;
                    step_data[n_steps] = d;
                    step_exp[n_steps] = e;
                    step_cycles += step_length(a, g, e);
                    n_steps++;
                end
            end
            $fclose(fd);
            if (n_steps == 0)
            begin
                report_failure("golden file holds no steps");
            end
        end
    endtask

    task automatic run_step(input int s);
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] exp;
        int count;
        int kept;
        arg = step_arg[s];
        data = step_data[s];
        exp = step_exp[s];
        case (step_act[s])
            32'h0:
            begin
                repeat (arg) @(negedge CLK_40);
            end
            32'h1:
            begin
                @(negedge CLK_40);
                i_trigger = 1'b1;
                @(negedge CLK_40);
                i_trigger = 1'b0;
                check_value("o_cmd_start", 32'(o_cmd_start), exp);
                if (exp[0])
                begin
                    // accepted trigger takes the next number
                    push_expected(0, 32'h8000_0000 | 32'(trig_num));
                    trig_num++;
                    model_busy = 1'b1;
                end
                check_value("o_busy", 32'(o_busy), 32'(model_busy));
            end
            32'h2:
            begin
                @(negedge CLK_40);
                i_cmd_ready = 1'b1;
                @(negedge CLK_40);
                i_cmd_ready = 1'b0;
                // busy ends once the ready rise is seen
                while (o_busy)
                begin
                    @(negedge CLK_40);
                end
                model_busy = 1'b0;
            end
            32'h3:
            begin
                // count in bits 15:8, first kept words in 7:0
                count = int'(exp[15:8]);
                kept = int'(exp[7:0]);
                for (int i = 0; i < count; i++)
                begin
                    @(negedge CLK_40);
                    i_hit_valid[arg] = 1'b1;
                    i_hit_data[arg*HIT_W +: HIT_W] = HIT_W'(data + i);
                    if (i < kept)
                    begin
                        push_expected(int'(arg) + 1, {5'b0, 3'(arg + 1), HIT_W'(data + i)});
                    end
                end
                @(negedge CLK_40);
                i_hit_valid = '0;
            end
            32'h4:
            begin
                @(negedge CLK_40);
                i_src_enable = arg[N_HIT:0];
            end
            32'h5:
            begin
                @(negedge CLK_40);
                i_veto = arg[0];
            end
            32'h6:
            begin
                @(negedge CLK_40);
                for (int i = 0; i < int'(arg); i++)
                begin
                    while (!o_not_empty)
                    begin
                        @(negedge CLK_40);
                    end
                    i_read = 1'b1;
                    @(negedge CLK_40);
                    i_read = 1'b0;
                    check_value("o_data_valid", 32'(o_data_valid), 32'h1);
                    route_read_word(o_data);
                end
            end
            32'h7:
            begin
                @(negedge CLK_40);
                i_clear_error = 1'b1;
                @(negedge CLK_40);
                i_clear_error = 1'b0;
            end
            32'h8:
            begin
                @(negedge CLK_40);
                i_trigger_enable = arg[0];
            end
            32'h9:
            begin
                @(negedge CLK_40);
                case (arg)
                    32'h0: check_value("o_near_full", 32'(o_near_full), exp);
                    32'h1: check_value("o_full", 32'(o_full), exp);
                    32'h2: check_value("o_read_error", 32'(o_read_error), exp);
                    32'h3: check_value("o_hit_overflow", 32'(o_hit_overflow), exp);
                    32'h4: check_value("o_not_empty", 32'(o_not_empty), exp);
                    32'h5: check_value("o_busy", 32'(o_busy), exp);
                    default: report_failure($sformatf("step %0d asks for unknown status", s));
                endcase
            end
            32'ha:
            begin
                // strobe without waiting for data
                @(negedge CLK_40);
                i_read = 1'b1;
                @(negedge CLK_40);
                i_read = 1'b0;
                check_value("o_data_valid", 32'(o_data_valid), exp);
            end
            default:
            begin
                report_failure($sformatf("step %0d has unknown action %h", s, step_act[s]));
            end
        endcase
    endtask

    initial
    begin
        int prev_test;
        int test_err_base;
        int n_tests;
        CLK_40 = 1'b0;
        i_rst = 1'b1;
        i_trigger = 1'b0;
        i_trigger_enable = 1'b1;
        i_veto = 1'b0;
        i_cmd_ready = 1'b0;
        i_hit_valid = '0;
        i_hit_data = '0;
        i_src_enable = '1;
        i_read = 1'b0;
        i_clear_error = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        errors = 0;
        checks = 0;
        trig_num = 0;
        model_busy = 1'b0;
        prev_test = -1;
        test_err_base = 0;
        n_tests = 0;
        load_steps();
        cycle_limit = 10 * step_cycles;
        repeat (8) @(negedge CLK_40);
        i_rst = 1'b0;
        for (int s = 0; s < n_steps; s++)
        begin
            if (int'(step_test[s]) != prev_test)
            begin
                if (prev_test >= 0)
                begin
                    $display("test %0d finished with %0d errors", prev_test,
                             errors - test_err_base);
                end
                prev_test = int'(step_test[s]);
                test_err_base = errors;
                n_tests++;
            end
            run_step(s);
        end
        if (prev_test >= 0)
        begin
            $display("test %0d finished with %0d errors", prev_test, errors - test_err_base);
        end
        // every expected word must have come out
        for (int k = 0; k <= N_HIT; k++)
        begin
            if (exp_rd[k] != exp_wr[k])
            begin
                report_failure($sformatf("%0d expected words of source %0d were never read",
                                         exp_wr[k] - exp_rd[k], k));
            end
        end
        if (i_readout_top.i_readout_checker.fail_count != 0)
        begin
            report_failure($sformatf("%0d assertion failures in the bound checker",
                                     i_readout_top.i_readout_checker.fail_count));
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- testbench/readout_golden.txt
// test action arg data expect (hex); 0 idle 1 trig 2 ready 3 hits(count<<8|kept) 4 enables
// 5 veto 6 read 7 clear 8 trig en 9 check(0 nf 1 full 2 err 3 ovf 4 nempty 5 busy) a raw read
1 1 0 0 1
1 0 5 0 0
1 9 5 0 1
1 2 0 0 0
1 1 0 0 1
1 2 0 0 0
1 1 0 0 1
1 2 0 0 0
1 6 3 0 0
2 1 0 0 1
2 1 0 0 0
2 2 0 0 0
2 5 1 0 0
2 1 0 0 0
2 5 0 0 0
2 8 0 0 0
2 1 0 0 0
2 8 1 0 0
2 1 0 0 1
2 2 0 0 0
2 6 2 0 0
3 3 0 123456 0101
3 3 1 abcdef 0101
3 3 2 000001 0101
3 3 0 654321 0101
3 6 4 0 0
4 4 d 0 0
4 3 0 111111 0202
4 3 1 333333 0101
4 6 1 0 0
4 0 4 0 0
4 9 4 0 0
4 4 f 0 0
4 6 2 0 0
5 3 2 500000 0c0c
5 0 4 0 0
5 9 0 0 1
5 9 1 0 0
5 3 2 50000c 0404
5 0 4 0 0
5 9 1 0 1
5 3 0 600000 0908
5 9 3 0 1
5 6 18 0 0
5 9 1 0 0
5 9 4 0 0
6 9 4 0 0
6 a 0 0 0
6 9 2 0 1
6 0 3 0 0
6 9 2 0 1
6 7 0 0 0
6 9 2 0 0

//--- filelist.f
logic/readout_pkg.sv
logic/trigger_unit.sv
logic/source_fifo.sv
logic/readout_arbiter.sv
logic/host_reader.sv
logic/readout_top.sv
testbench/readout_checker.sv
testbench/tb_readout_top.sv

//--- Bender.yml
package:
  name: pixel_readout

sources:
  - logic/readout_pkg.sv
  - logic/trigger_unit.sv
  - logic/source_fifo.sv
  - logic/readout_arbiter.sv
  - logic/host_reader.sv
  - logic/readout_top.sv
  - target: test
    files:
      - testbench/readout_checker.sv
      - testbench/tb_readout_top.sv
